/* Bender.yml */
package:
  name: mini_core

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/instr_buffer.sv
      - hdl/regfile.sv
      - hdl/exec_unit.sv
      - hdl/mini_core_top.sv
  - target: test
    files:
      - bench/mini_core_assert.sv
      - bench/mini_core_tb.sv

/* bench/mini_core_assert.sv */
module mini_core_assert (
    input logic                      clk,
    input logic                      arst_n_i,
    input logic                      imem_req_o,
    input logic [core_pkg::XLEN-1:0] imem_addr_o,
    input logic                      imem_gnt_i,
    input logic                      commit_valid_o,
    input core_pkg::commit_t         commit_o,
    input logic                      commit_ready_i
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned err_cnt = 0;  // Polled by the testbench

    reset_idle: assert property (@(posedge clk) !arst_n_i |-> !imem_req_o && !commit_valid_o)
        else begin
            $error("Request or commit active during reset");
            err_cnt++;
        end

    // First cycle out of reset stays quiet
    release_idle: assert property (@(posedge clk)
        $rose(arst_n_i) |-> !imem_req_o && !commit_valid_o)
        else begin
            $error("Request or commit active in the first cycle after reset");
            err_cnt++;
        end

    first_fetch: assert property (@(posedge clk)
        $rose(arst_n_i) |=> imem_req_o && (imem_addr_o == core_pkg::RESET_PC))
        else begin
            $error("First instruction request is not at the reset address");
            err_cnt++;
        end

    addr_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        imem_req_o && !imem_gnt_i |=> $stable(imem_addr_o))
        else begin
            $error("Fetch address changed while the request was waiting");
            err_cnt++;
        end

    // Held record must not move until taken
    commit_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_valid_o && !commit_ready_i |=> commit_valid_o && $stable(commit_o))
        else begin
            $error("Commit record dropped or changed before it was accepted");
            err_cnt++;
        end

endmodule

bind mini_core_top mini_core_assert u_chk (.*);

/* bench/mini_core_tb.sv */
module mini_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned MEM_WORDS  = 64;
    localparam int unsigned SELF_LOOPS = 8;  // Checked turns of the final self-loop

    logic                      clk;
    logic                      arst_n_i;
    logic                      imem_req_o;
    logic [core_pkg::XLEN-1:0] imem_addr_o;
    logic                      imem_gnt_i;
    logic [core_pkg::XLEN-1:0] imem_rdata_i;
    logic                      commit_valid_o;
    core_pkg::commit_t         commit_o;
    logic                      commit_ready_i;

    logic [core_pkg::XLEN-1:0] imem [MEM_WORDS];
    int unsigned               prog_len;
    core_pkg::commit_t         exp_q [$];
    core_pkg::commit_t         exp_head;   // Next record the DUT has to retire
    int unsigned               exp_total;
    int unsigned               done_cnt = 0;
    logic                      commit_fire = 1'b0;  // Commit handshake of the current cycle

    mini_core_top u_dut (.*);

    assign imem_rdata_i = imem[imem_addr_o[7:2]];  // Word index, wraps every 256 bytes

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", why);
    endtask

    task automatic emit_i(core_pkg::opcode_e op, logic [4:0] rd, logic [4:0] rs1,
                          logic [15:0] imm);
        logic [core_pkg::XLEN-1:0] w;
        w = '0;
        w[core_pkg::OPC_MSB:core_pkg::OPC_LSB] = op;
        w[core_pkg::RD_MSB:core_pkg::RD_LSB]   = rd;
        w[core_pkg::RS1_MSB:core_pkg::RS1_LSB] = rs1;
        w[core_pkg::IMM_MSB:core_pkg::IMM_LSB] = imm;
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic emit_r(core_pkg::opcode_e op, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        emit_i(op, rd, rs1, 16'(rs2) << core_pkg::RS2_LSB);
    endtask

    // Short BEQ offsets leave rs2 at r0, so a branch tests rs1 against zero
    task automatic load_program();
        core_pkg::opcode_e op;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = {core_pkg::OP_ADDI, 5'd1, 5'd1, 16'(i)};  // Filler past the end
        end
        prog_len = 0;
        emit_i(core_pkg::OP_ADDI, 1, 0, 16'($urandom) | 16'h1);  // Never zero
        emit_i(core_pkg::OP_ADDI, 2, 0, 16'($urandom));
        emit_r(core_pkg::OP_ADD, 3, 1, 2);
        emit_r(core_pkg::OP_SUB, 4, 3, 1);
        emit_r(core_pkg::OP_AND, 5, 4, 2);
        emit_r(core_pkg::OP_OR, 6, 5, 1);
        emit_i(core_pkg::OP_ADDI, 0, 6, 16'($urandom));  // Write to r0 dropped
        emit_r(core_pkg::OP_ADD, 7, 0, 2);
        emit_r(core_pkg::OP_SUB, 8, 1, 1);
        emit_i(core_pkg::OP_BEQ, 0, 8, 16'd3);   // Taken, skips two
        emit_r(core_pkg::OP_ADD, 9, 3, 3);
        emit_r(core_pkg::OP_OR, 10, 1, 2);
        emit_i(core_pkg::OP_BEQ, 0, 1, 16'd2);   // Not taken
        for (int k = 0; k < 36; k++) begin
            op = core_pkg::opcode_e'($urandom % 7);
            if (op == core_pkg::OP_BEQ) begin
                emit_i(op, 0, 5'($urandom % 8), 16'(1 + $urandom % 3));
            end else if (op == core_pkg::OP_ADDI) begin
                emit_i(op, 5'($urandom % 8), 5'($urandom % 8), 16'($urandom));
            end else begin
                emit_r(op, 5'($urandom % 8), 5'($urandom % 8), 5'($urandom % 8));
            end
        end
        repeat (3) emit_r(core_pkg::OP_NOP, 0, 0, 0);  // Landing room for late branches
        emit_i(core_pkg::OP_BEQ, 0, 0, 16'd0);
    endtask

    task automatic run_model();
        logic [core_pkg::XLEN-1:0]       regs [core_pkg::NUM_REGS];
        logic [core_pkg::XLEN-1:0]       pc;
        logic [core_pkg::XLEN-1:0]       next_pc;
        logic [core_pkg::XLEN-1:0]       ins;
        logic [core_pkg::XLEN-1:0]       a;
        logic [core_pkg::XLEN-1:0]       b;
        logic [core_pkg::XLEN-1:0]       imm;
        logic [core_pkg::XLEN-1:0]       res;
        logic [core_pkg::REG_ADDR_W-1:0] rd;
        logic [5:0]                      opc;
        core_pkg::commit_t               c;
        int unsigned                     loops;
        foreach (regs[i]) regs[i] = '0;
        pc    = core_pkg::RESET_PC;
        loops = 0;
        while (loops < SELF_LOOPS) begin
            ins     = imem[pc[7:2]];
            opc     = ins[core_pkg::OPC_MSB:core_pkg::OPC_LSB];
            rd      = ins[core_pkg::RD_MSB:core_pkg::RD_LSB];
            a       = regs[ins[core_pkg::RS1_MSB:core_pkg::RS1_LSB]];
            b       = regs[ins[core_pkg::RS2_MSB:core_pkg::RS2_LSB]];
            imm     = {{16{ins[core_pkg::IMM_MSB]}}, ins[core_pkg::IMM_MSB:core_pkg::IMM_LSB]};
            res     = '0;
            next_pc = pc + 4;
            case (opc)
                core_pkg::OP_ADD:  res = a + b;
                core_pkg::OP_SUB:  res = a - b;
                core_pkg::OP_AND:  res = a & b;
                core_pkg::OP_OR:   res = a | b;
                core_pkg::OP_ADDI: res = a + imm;
                core_pkg::OP_BEQ:  next_pc = (a == b) ? pc + (imm << 2) : next_pc;
                default: ;
            endcase
            c    = '0;
            c.pc = pc;
            if ((opc inside {core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND,
                             core_pkg::OP_OR, core_pkg::OP_ADDI}) && (rd != '0)) begin
                c.we     = 1'b1;
                c.waddr  = rd;
                c.wdata  = res;
                regs[rd] = res;
            end
            exp_q.push_back(c);
            if (next_pc == pc) loops++;
            pc = next_pc;
        end
    endtask

    task automatic drive_handshakes();
        int unsigned stall;
        stall = 0;
        forever begin
            @(posedge clk);
            #1;
            imem_gnt_i = ($urandom % 4) != 0;
            if (stall == 0 && ($urandom % 16) == 0) begin
                stall = 10;  // Long enough to fill the buffer
            end
            if (stall != 0) begin
                commit_ready_i = 1'b0;
                stall--;
            end else begin
                commit_ready_i = ($urandom % 4) != 0;
            end
        end
    endtask

    // Both handshake signals have settled by the falling edge
    always @(negedge clk) begin
        commit_fire = arst_n_i && commit_valid_o && commit_ready_i;
    end

    always @(posedge clk) begin
        if (commit_fire && done_cnt < exp_total) begin
            void'(exp_q.pop_front());
            done_cnt++;
            if (exp_q.size() != 0) exp_head = exp_q[0];
        end
    end

    commit_check: assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_valid_o && commit_ready_i && (done_cnt < exp_total) |-> commit_o == exp_head)
        else begin
            $display("Mismatch at %0t: commit expected %h, got %h", $time,
                     $sampled(exp_head), $sampled(commit_o));
            abort_run("Retired instruction differs from the reference model");
        end

    initial begin
        wait (u_dut.u_chk.err_cnt != 0);
        abort_run("A protocol assertion on the DUT ports failed");
    end

    initial begin
        int unsigned limit;
        void'($urandom(32'hb426_cee6));
        arst_n_i       = 1'b1;
        imem_gnt_i     = 1'b0;
        commit_ready_i = 1'b0;
        load_program();
        run_model();
        exp_total = exp_q.size();
        exp_head  = exp_q[0];
        limit     = exp_total * 20 + 200;
        fork
            drive_handshakes();
            begin
                repeat (limit) @(posedge clk);
                abort_run("Timeout: not all expected instructions retired in time");
            end
        join_none
        #1 arst_n_i = 1'b0;
        repeat (3) @(posedge clk);
        #1 arst_n_i = 1'b1;
        wait (done_cnt == exp_total);
        @(posedge clk);
        #1;
        if (u_dut.u_chk.err_cnt == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("Protocol assertions failed during the run");
        end
    end

endmodule

/* hdl/core_pkg.sv */
package core_pkg;

    // Datapath and address width
    localparam int unsigned XLEN = 32;

    // Register file geometry
    localparam int unsigned NUM_REGS   = 32;
    localparam int unsigned REG_ADDR_W = 5;

    // Instruction buffer geometry, depth is a power of two
    localparam int unsigned IB_DEPTH = 4;
    localparam int unsigned IB_PTR_W = 2;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // Instruction field positions
    localparam int unsigned OPC_MSB = 31;
    localparam int unsigned OPC_LSB = 26;
    localparam int unsigned RD_MSB  = 25;
    localparam int unsigned RD_LSB  = 21;
    localparam int unsigned RS1_MSB = 20;
    localparam int unsigned RS1_LSB = 16;
    localparam int unsigned RS2_MSB = 15;
    localparam int unsigned RS2_LSB = 11;
    localparam int unsigned IMM_MSB = 15; // Overlaps rs2, signed
    localparam int unsigned IMM_LSB = 0;
    localparam int unsigned IMM_W   = 16;

    typedef enum logic [5:0] {
        OP_NOP  = 6'd0,
        OP_ADD  = 6'd1,
        OP_SUB  = 6'd2,
        OP_AND  = 6'd3,
        OP_OR   = 6'd4,
        OP_ADDI = 6'd5, // rd = rs1 + sext(imm)
        OP_BEQ  = 6'd6  // Taken target is pc + 4 * sext(imm)
    } opcode_e;

    // Pushed by fetch into the buffer
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_entry_t;

    // Branch redirect from execute
    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

    // One retired instruction
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr; // Zero when we is low
        logic [XLEN-1:0]       wdata; // Zero when we is low
    } commit_t;

endpackage

/* hdl/exec_unit.sv */
module exec_unit (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // From the buffer
    input  logic                   in_valid_i,
    input  core_pkg::fetch_entry_t in_entry_i,
    output logic                   in_ready_o,
    // To fetch and buffer
    output core_pkg::redirect_t    redirect_o,
    // Commit port
    output logic                   commit_valid_o,
    output core_pkg::commit_t      commit_o,
    input  logic                   commit_ready_i
);

    core_pkg::opcode_e               opcode;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic [core_pkg::REG_ADDR_W-1:0] rs1;
    logic [core_pkg::REG_ADDR_W-1:0] rs2;
    logic [core_pkg::XLEN-1:0]       rs1_data;
    logic [core_pkg::XLEN-1:0]       rs2_data;
    logic [core_pkg::XLEN-1:0]       imm_ext;
    logic [core_pkg::XLEN-1:0]       alu_res;
    logic                            writes_rd;
    logic                            is_beq;
    logic                            accept;
    core_pkg::commit_t               commit_d;
    core_pkg::commit_t               commit_q;
    logic                            commit_valid_q;

    // Field extraction
    assign opcode = core_pkg::opcode_e'(in_entry_i.instr[core_pkg::OPC_MSB:core_pkg::OPC_LSB]);
    assign rd     = in_entry_i.instr[core_pkg::RD_MSB:core_pkg::RD_LSB];
    assign rs1    = in_entry_i.instr[core_pkg::RS1_MSB:core_pkg::RS1_LSB];
    assign rs2    = in_entry_i.instr[core_pkg::RS2_MSB:core_pkg::RS2_LSB];
    assign imm_ext = {{(core_pkg::XLEN - core_pkg::IMM_W){in_entry_i.instr[core_pkg::IMM_MSB]}},
                      in_entry_i.instr[core_pkg::IMM_MSB:core_pkg::IMM_LSB]};

    // Free commit slot, or the held record leaves this cycle
    assign in_ready_o = !commit_valid_q || commit_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    regfile u_regfile (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .raddr_a_i (rs1),
        .raddr_b_i (rs2),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data),
        .we_i      (accept && commit_d.we),  // Written on the retiring edge
        .waddr_i   (commit_d.waddr),
        .wdata_i   (commit_d.wdata)
    );

    always_comb begin
        alu_res   = '0;
        writes_rd = 1'b0;
        is_beq    = 1'b0;
        case (opcode)
            core_pkg::OP_ADD: begin
                alu_res   = rs1_data + rs2_data;
                writes_rd = 1'b1;
            end
            core_pkg::OP_SUB: begin
                alu_res   = rs1_data - rs2_data;
                writes_rd = 1'b1;
            end
            core_pkg::OP_AND: begin
                alu_res   = rs1_data & rs2_data;
                writes_rd = 1'b1;
            end
            core_pkg::OP_OR: begin
                alu_res   = rs1_data | rs2_data;
                writes_rd = 1'b1;
            end
            core_pkg::OP_ADDI: begin
                alu_res   = rs1_data + imm_ext;
                writes_rd = 1'b1;
            end
            core_pkg::OP_BEQ: is_beq = 1'b1;
            default: ;  // NOP and unknown opcodes
        endcase
    end

    // Record fields are zeroed when nothing is written
    assign commit_d.pc    = in_entry_i.pc;
    assign commit_d.we    = writes_rd && (rd != '0);
    assign commit_d.waddr = commit_d.we ? rd : '0;
    assign commit_d.wdata = commit_d.we ? alu_res : '0;

    assign redirect_o.taken  = accept && is_beq && (rs1_data == rs2_data);
    assign redirect_o.target = in_entry_i.pc + {imm_ext[core_pkg::XLEN-3:0], 2'b00};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            commit_valid_q <= 1'b0;
        end else if (accept) begin
            commit_valid_q <= 1'b1;
        end else if (commit_ready_i) begin
            commit_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            commit_q <= commit_d;
        end
    end

    assign commit_valid_o = commit_valid_q;
    assign commit_o       = commit_q;

endmodule

/* hdl/fetch_unit.sv */
module fetch_unit (
    input  logic                         clk,
    input  logic                         arst_n_i,
    // Instruction memory
    output logic                         imem_req_o,
    output logic [core_pkg::XLEN-1:0]    imem_addr_o,
    input  logic                         imem_gnt_i,
    input  logic [core_pkg::XLEN-1:0]    imem_rdata_i,
    // Buffer push side
    output logic                         push_valid_o,
    output core_pkg::fetch_entry_t       push_entry_o,
    input  logic                         push_ready_i,
    // From execute
    input  core_pkg::redirect_t          redirect_i
);

    logic [core_pkg::XLEN-1:0] pc_q;
    logic                      run_q;   // Low until the first edge after reset
    logic                      fire;

    // Request only with room in the buffer and no redirect pending
    assign imem_req_o  = run_q && push_ready_i && !redirect_i.taken;
    assign imem_addr_o = pc_q;

    assign fire = imem_req_o && imem_gnt_i;

    // Read data arrives with the grant
    assign push_valid_o       = fire;
    assign push_entry_o.pc    = pc_q;
    assign push_entry_o.instr = imem_rdata_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // Address only moves on a grant or a redirect
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= core_pkg::RESET_PC;
        end else if (redirect_i.taken) begin
            pc_q <= redirect_i.target;
        end else if (fire) begin
            pc_q <= pc_q + core_pkg::XLEN'(4);
        end
    end

endmodule

/* hdl/instr_buffer.sv */
module instr_buffer (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // From fetch
    input  logic                   push_valid_i,
    input  core_pkg::fetch_entry_t push_entry_i,
    output logic                   push_ready_o,
    // To execute
    output logic                   pop_valid_o,
    output core_pkg::fetch_entry_t pop_entry_o,
    input  logic                   pop_ready_i,
    // Taken branch
    input  logic                   flush_i
);

    core_pkg::fetch_entry_t mem [core_pkg::IB_DEPTH];

    logic [core_pkg::IB_PTR_W-1:0] wr_ptr_q;
    logic [core_pkg::IB_PTR_W-1:0] rd_ptr_q;
    logic [core_pkg::IB_PTR_W:0]   count_q;  // One extra bit to tell full from empty
    logic                          push_fire;
    logic                          pop_fire;

    assign push_ready_o = (count_q != (core_pkg::IB_PTR_W + 1)'(core_pkg::IB_DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign pop_entry_o  = mem[rd_ptr_q];

    // A push in the flush cycle is dropped
    assign push_fire = push_valid_i && push_ready_o && !flush_i;
    assign pop_fire  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr_q] <= push_entry_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1; // Wraps at depth
            end
            if (pop_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // Both or neither
            endcase
        end
    end

endmodule

/* hdl/mini_core_top.sv */
module mini_core_top (
    input  logic                      clk,
    input  logic                      arst_n_i,
    // Instruction memory
    output logic                      imem_req_o,
    output logic [core_pkg::XLEN-1:0] imem_addr_o,
    input  logic                      imem_gnt_i,
    input  logic [core_pkg::XLEN-1:0] imem_rdata_i,
    // Retired instructions
    output logic                      commit_valid_o,
    output core_pkg::commit_t         commit_o,
    input  logic                      commit_ready_i
);

    logic                   push_valid;
    logic                   push_ready;
    core_pkg::fetch_entry_t push_entry;
    logic                   pop_valid;
    logic                   pop_ready;
    core_pkg::fetch_entry_t pop_entry;
    core_pkg::redirect_t    redirect;

    fetch_unit u_fetch (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .imem_gnt_i   (imem_gnt_i),
        .imem_rdata_i (imem_rdata_i),
        .push_valid_o (push_valid),
        .push_entry_o (push_entry),
        .push_ready_i (push_ready),
        .redirect_i   (redirect)
    );

    instr_buffer u_ibuf (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .push_valid_i (push_valid),
        .push_entry_i (push_entry),
        .push_ready_o (push_ready),
        .pop_valid_o  (pop_valid),
        .pop_entry_o  (pop_entry),
        .pop_ready_i  (pop_ready),
        .flush_i      (redirect.taken)  // Drop wrong-path entries
    );

    exec_unit u_exec (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .in_valid_i     (pop_valid),
        .in_entry_i     (pop_entry),
        .in_ready_o     (pop_ready),
        .redirect_o     (redirect),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .commit_ready_i (commit_ready_i)
    );

endmodule

/* hdl/regfile.sv */
module regfile (
    input  logic                            clk,
    input  logic                            arst_n_i,
    // Read ports
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
    output logic [core_pkg::XLEN-1:0]       rdata_a_o,
    output logic [core_pkg::XLEN-1:0]       rdata_b_o,
    // Write port
    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i
);

    logic [core_pkg::XLEN-1:0] regs [core_pkg::NUM_REGS];

    // r0 is never written, so it keeps its reset value
    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

endmodule

/* mini_core.f */
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/instr_buffer.sv
hdl/regfile.sv
hdl/exec_unit.sv
hdl/mini_core_top.sv
bench/mini_core_assert.sv
bench/mini_core_tb.sv
